/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_tactics_display -f verilog.f -o sim_tactics
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tactics > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
else
    exit 1
fi

/* src/pixel_compositor.sv */
module pixel_compositor (
    input  logic                  pclk,
    input  logic                  reset,
    input  tactics_pkg::layer_t   layer_i,
    input  tactics_pkg::overlay_t overlay_i,
    input  tactics_pkg::sync_t    sync_i,
    output tactics_pkg::rgb_t     rgb_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o
);
    import tactics_pkg::*;

    rgb_t  mix_rgb;
    sync_t sync_q;

    always_comb begin
        if (overlay_i.frame)
            mix_rgb = overlay_i.attack ? COLOR_ATTACK : COLOR_MOVE;
        else if (overlay_i.tint && !layer_i.is_bar)
            mix_rgb = layer_i.pixel + (overlay_i.attack ? TINT_ATTACK : TINT_MOVE);
        else
            mix_rgb = layer_i.pixel;
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            rgb_o        <= '0;
            sync_q.hsync <= 1'b1;
            sync_q.vsync <= 1'b1;
            sync_q.de    <= 1'b0;
        end else begin
            rgb_o  <= sync_i.de ? mix_rgb : '0;   // black in blanking
            sync_q <= sync_i;
        end
    end

    assign hsync_o = sync_q.hsync;
    assign vsync_o = sync_q.vsync;
    assign de_o    = sync_q.de;

endmodule

/* src/range_overlay.sv */
module range_overlay (
    input  tactics_pkg::scan_pos_t   pos_i,
    input  tactics_pkg::tile_kind_t  kind_i,
    input  tactics_pkg::unit_t       knight_i,
    input  tactics_pkg::map_addr_t   selected_i,
    input  tactics_pkg::map_addr_t   action_i,
    input  tactics_pkg::unit_state_e player_state_i,
    output tactics_pkg::overlay_t    overlay_o
);
    import tactics_pkg::*;

    logic active;
    logic in_band;
    logic walkable;
    logic knight_acts;
    logic near_four;
    logic same_line;
    logic in_range;
    logic on_selected;

    assign active = (player_state_i == STATE_MOVE) || (player_state_i == STATE_ATTACK);

    // outer two pixels of the tile
    assign in_band = (pos_i.tile_x < FRAME_WIDTH) ||
                     (pos_i.tile_x >= tile_pix_t'(TILE_SIZE - int'(FRAME_WIDTH))) ||
                     (pos_i.tile_y < FRAME_WIDTH) ||
                     (pos_i.tile_y >= tile_pix_t'(TILE_SIZE - int'(FRAME_WIDTH)));

    assign walkable    = kind_i < WALKABLE_LIMIT;
    assign on_selected = pos_i.map_addr == selected_i;

    ////////////////////////////////////////////////////////////////////////////
    // action range
    ////////////////////////////////////////////////////////////////////////////

    assign knight_acts = action_i == knight_i.pos;

    assign near_four = (pos_i.map_addr == action_i - 11'd1) ||
                       (pos_i.map_addr == action_i + 11'd1) ||
                       (pos_i.map_addr == action_i - MAP_COLS) ||
                       (pos_i.map_addr == action_i + MAP_COLS);

    // wizard reaches the whole row and column
    assign same_line = (pos_i.map_addr / MAP_COLS == action_i / MAP_COLS) ||
                       (pos_i.map_addr % MAP_COLS == action_i % MAP_COLS);

    assign in_range = knight_acts ? near_four : same_line;

    always_comb begin
        overlay_o.attack = player_state_i == STATE_ATTACK;
        overlay_o.frame  = 1'b0;
        overlay_o.tint   = 1'b0;
        if (active) begin
            if (on_selected) begin
                overlay_o.frame = in_band;
                overlay_o.tint  = !in_band;
            end else begin
                overlay_o.frame = in_range && walkable && in_band;
            end
        end
    end

endmodule

/* src/scan_timing.sv */
module scan_timing (
    input  logic                  pclk,
    input  logic                  reset,
    input  tactics_pkg::coord_t   scroll_x_i,
    input  tactics_pkg::coord_t   scroll_y_i,
    output tactics_pkg::scan_pos_t pos_o,
    output tactics_pkg::sync_t    sync_o
);
    import tactics_pkg::*;

    coord_t pixel_cnt;
    coord_t line_cnt;
    coord_t vis_x;
    coord_t vis_y;
    coord_t scr_x;
    coord_t scr_y;

    ////////////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pclk) begin
        if (reset) begin
            pixel_cnt <= '0;
            line_cnt  <= '0;
        end else if (pixel_cnt == H_TOTAL - 11'd1) begin
            pixel_cnt <= '0;
            if (line_cnt == V_TOTAL - 11'd1)
                line_cnt <= '0;
            else
                line_cnt <= line_cnt + 11'd1;
        end else begin
            pixel_cnt <= pixel_cnt + 11'd1;
        end
    end

    // syncs sit right after the front porch
    always_comb begin
        sync_o.hsync = !((pixel_cnt >= H_DISPLAY + H_FRONT) &&
                         (pixel_cnt <  H_DISPLAY + H_FRONT + H_SYNC));
        sync_o.vsync = !((line_cnt >= V_DISPLAY + V_FRONT) &&
                         (line_cnt <  V_DISPLAY + V_FRONT + V_SYNC));
        sync_o.de    = (pixel_cnt < H_DISPLAY) && (line_cnt < V_DISPLAY);
    end

    ////////////////////////////////////////////////////////////////////////////
    // scrolled map position
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        vis_x = (pixel_cnt < H_DISPLAY) ? pixel_cnt : '0;   // blanking maps to col 0
        vis_y = (line_cnt < V_DISPLAY) ? line_cnt : '0;
        scr_x = vis_x + scroll_x_i;
        scr_y = vis_y + scroll_y_i;

        pos_o.map_addr = map_addr_t'(scr_x >> TILE_SHIFT) +
                         MAP_COLS * map_addr_t'(scr_y >> TILE_SHIFT);
        pos_o.tile_x   = tile_pix_t'(scr_x);
        pos_o.tile_y   = tile_pix_t'(scr_y);
    end

endmodule

/* src/tactics_display.sv */
module tactics_display (
    input  logic                     pclk,
    input  logic                     reset,
    input  tactics_pkg::coord_t      scroll_x_i,
    input  tactics_pkg::coord_t      scroll_y_i,
    input  logic                     map_we_i,
    input  tactics_pkg::map_addr_t   map_waddr_i,
    input  tactics_pkg::tile_kind_t  map_wdata_i,
    input  tactics_pkg::unit_t       knight_i,
    input  tactics_pkg::unit_t       wizard_i,
    input  tactics_pkg::anim_count_t anim_count_i,
    input  tactics_pkg::map_addr_t   selected_i,
    input  tactics_pkg::map_addr_t   action_i,
    input  tactics_pkg::unit_state_e player_state_i,
    output tactics_pkg::rgb_t        rgb_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output logic                     de_o
);
    import tactics_pkg::*;

    scan_pos_t  scan_pos;    // stage 0
    sync_t      scan_sync;
    tile_kind_t tile_kind;   // stage 1
    scan_pos_t  tile_pos;
    sync_t      tile_sync;
    layer_t     layer;
    overlay_t   overlay;

    scan_timing u_scan (
        .pclk       (pclk),
        .reset      (reset),
        .scroll_x_i (scroll_x_i),
        .scroll_y_i (scroll_y_i),
        .pos_o      (scan_pos),
        .sync_o     (scan_sync)
    );

    tile_map_ram u_map (
        .pclk        (pclk),
        .reset       (reset),
        .pos_i       (scan_pos),
        .sync_i      (scan_sync),
        .map_we_i    (map_we_i),
        .map_waddr_i (map_waddr_i),
        .map_wdata_i (map_wdata_i),
        .kind_o      (tile_kind),
        .pos_o       (tile_pos),
        .sync_o      (tile_sync)
    );

    unit_layer u_layer (
        .pos_i (tile_pos), .kind_i (tile_kind), .knight_i (knight_i), .wizard_i (wizard_i),
        .anim_count_i (anim_count_i), .layer_o (layer)
    );

    range_overlay u_overlay (
        .pos_i (tile_pos), .kind_i (tile_kind), .knight_i (knight_i),
        .selected_i (selected_i), .action_i (action_i),
        .player_state_i (player_state_i), .overlay_o (overlay)
    );

    pixel_compositor u_comp (
        .pclk (pclk), .reset (reset), .layer_i (layer), .overlay_i (overlay),
        .sync_i (tile_sync), .rgb_o (rgb_o),
        .hsync_o (hsync_o), .vsync_o (vsync_o), .de_o (de_o)
    );

endmodule

/* src/tactics_pkg.sv */
package tactics_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [11:0] rgb_t;        // 4:4:4
    typedef logic [10:0] coord_t;      // scrolled pixel coordinate
    typedef logic [10:0] map_addr_t;   // col + 40 * row
    typedef logic [3:0]  tile_kind_t;
    typedef logic [4:0]  tile_pix_t;   // position inside a tile
    typedef logic [6:0]  hp_t;
    typedef logic [3:0]  anim_count_t;

    typedef enum logic [1:0] {
        STATE_MOVE,
        STATE_ATTACK,
        STATE_HIT,
        STATE_IDLE
    } unit_state_e;

    typedef struct packed {
        logic hsync;   // active low
        logic vsync;   // active low
        logic de;
    } sync_t;

    typedef struct packed {
        map_addr_t map_addr;
        tile_pix_t tile_x;
        tile_pix_t tile_y;
    } scan_pos_t;

    typedef struct packed {
        map_addr_t   pos;
        hp_t         hp;
        unit_state_e state;
    } unit_t;

    typedef struct packed {
        rgb_t pixel;
        logic is_bar;   // health bar pixels never get tinted
    } layer_t;

    typedef struct packed {
        logic frame;
        logic tint;
        logic attack;   // picks attack colours over move colours
    } overlay_t;

    ////////////////////////////////////////////////////////////////////////////
    // timing and geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam coord_t H_DISPLAY = 11'd640;
    localparam coord_t H_FRONT   = 11'd16;
    localparam coord_t H_SYNC    = 11'd96;
    localparam coord_t H_BACK    = 11'd48;
    localparam coord_t H_TOTAL   = 11'd800;
    localparam coord_t V_DISPLAY = 11'd480;
    localparam coord_t V_FRONT   = 11'd10;
    localparam coord_t V_SYNC    = 11'd2;
    localparam coord_t V_BACK    = 11'd33;
    localparam coord_t V_TOTAL   = 11'd525;

    localparam int        TILE_SHIFT = 5;
    localparam int        TILE_SIZE  = 32;
    localparam map_addr_t MAP_COLS   = 11'd40;
    localparam int        MAP_DEPTH  = 2048;

    localparam tile_pix_t BAR_TOP     = 5'd2;
    localparam tile_pix_t BAR_BOTTOM  = 5'd3;
    localparam tile_pix_t FRAME_WIDTH = 5'd2;
    localparam tile_pix_t BODY_LEFT   = 5'd8;
    localparam tile_pix_t BODY_RIGHT  = 5'd23;
    localparam tile_pix_t BODY_TOP    = 5'd6;
    localparam tile_pix_t BODY_BOTTOM = 5'd29;

    localparam hp_t         KNIGHT_HP_MAX   = 7'd127;
    localparam hp_t         WIZARD_HP_MAX   = 7'd80;
    localparam tile_kind_t  WALKABLE_LIMIT  = 4'd3;
    localparam anim_count_t HIT_FLASH_START = 4'd8;

    ////////////////////////////////////////////////////////////////////////////
    // palette
    ////////////////////////////////////////////////////////////////////////////

    localparam rgb_t COLOR_BAR_FULL  = 12'hC00;
    localparam rgb_t COLOR_BAR_EMPTY = 12'hFFF;
    localparam rgb_t COLOR_MOVE      = 12'h4AF;
    localparam rgb_t COLOR_ATTACK    = 12'hF22;
    localparam rgb_t TINT_MOVE       = 12'h010;
    localparam rgb_t TINT_ATTACK     = 12'h100;
    localparam rgb_t HIT_FLASH       = 12'h200;
    localparam rgb_t COLOR_KNIGHT    = 12'h44C;
    localparam rgb_t COLOR_WIZARD    = 12'hA4C;

    // grass, dirt, sand are walkable; water and rock from kind 3 on
    localparam rgb_t TILE_PALETTE [16] = '{
        12'h3A3, 12'h864, 12'hDC8, 12'h37C, 12'h666, 12'h252, 12'h543, 12'h999,
        12'h18A, 12'h732, 12'hAA6, 12'h424, 12'h5B8, 12'hB85, 12'h333, 12'hCCC
    };

endpackage

/* src/tile_map_ram.sv */
module tile_map_ram (
    input  logic                    pclk,
    input  logic                    reset,
    input  tactics_pkg::scan_pos_t  pos_i,
    input  tactics_pkg::sync_t      sync_i,
    input  logic                    map_we_i,
    input  tactics_pkg::map_addr_t  map_waddr_i,
    input  tactics_pkg::tile_kind_t map_wdata_i,
    output tactics_pkg::tile_kind_t kind_o,
    output tactics_pkg::scan_pos_t  pos_o,
    output tactics_pkg::sync_t      sync_o
);
    import tactics_pkg::*;

    tile_kind_t mem [MAP_DEPTH];

    // write port for the game logic, read port for the scan
    always_ff @(posedge pclk) begin
        if (map_we_i)
            mem[map_waddr_i] <= map_wdata_i;
        kind_o <= mem[pos_i.map_addr];
        pos_o  <= pos_i;   // keep scan data lined up with the read
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            sync_o.hsync <= 1'b1;
            sync_o.vsync <= 1'b1;
            sync_o.de    <= 1'b0;
        end else begin
            sync_o <= sync_i;
        end
    end

endmodule

/* src/unit_layer.sv */
module unit_layer (
    input  tactics_pkg::scan_pos_t   pos_i,
    input  tactics_pkg::tile_kind_t  kind_i,
    input  tactics_pkg::unit_t       knight_i,
    input  tactics_pkg::unit_t       wizard_i,
    input  tactics_pkg::anim_count_t anim_count_i,
    output tactics_pkg::layer_t      layer_o
);
    import tactics_pkg::*;

    rgb_t tile_rgb;
    logic knight_here;
    logic wizard_here;

    ////////////////////////////////////////////////////////////////////////////
    // one unit on its tile: bar on top, flat body below
    ////////////////////////////////////////////////////////////////////////////

    function automatic layer_t draw_unit(
        input unit_t       unit,
        input hp_t         hp_max,
        input rgb_t        body_rgb,
        input scan_pos_t   pos,
        input rgb_t        back_rgb,
        input anim_count_t anim
    );
        logic [11:0] bar_len;
        logic        in_bar;
        logic        in_body;
        layer_t      res;

        bar_len = (12'(unit.hp) * 12'(TILE_SIZE)) / 12'(hp_max);   // 0..32 pixels
        in_bar  = (pos.tile_y >= BAR_TOP) && (pos.tile_y <= BAR_BOTTOM);
        in_body = (pos.tile_x >= BODY_LEFT) && (pos.tile_x <= BODY_RIGHT) &&
                  (pos.tile_y >= BODY_TOP) && (pos.tile_y <= BODY_BOTTOM);

        res.pixel  = back_rgb;
        res.is_bar = 1'b0;
        if (in_bar) begin
            res.is_bar = 1'b1;
            if (12'(pos.tile_x) < bar_len)
                res.pixel = COLOR_BAR_FULL;
            else
                res.pixel = COLOR_BAR_EMPTY;
        end else if (in_body) begin
            res.pixel = body_rgb;
            if (unit.state == STATE_HIT && anim > HIT_FLASH_START)
                res.pixel = body_rgb + HIT_FLASH;   // wraps in 12 bits
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // layer select
    ////////////////////////////////////////////////////////////////////////////

    assign tile_rgb    = TILE_PALETTE[kind_i];
    assign knight_here = (pos_i.map_addr == knight_i.pos) && (knight_i.hp != '0);
    assign wizard_here = (pos_i.map_addr == wizard_i.pos) && (wizard_i.hp != '0);

    always_comb begin
        if (knight_here) begin   // knight wins a shared tile
            layer_o = draw_unit(knight_i, KNIGHT_HP_MAX, COLOR_KNIGHT,
                                pos_i, tile_rgb, anim_count_i);
        end else if (wizard_here) begin
            layer_o = draw_unit(wizard_i, WIZARD_HP_MAX, COLOR_WIZARD,
                                pos_i, tile_rgb, anim_count_i);
        end else begin
            layer_o.pixel  = tile_rgb;
            layer_o.is_bar = 1'b0;
        end
    end

endmodule

/* tb/tb_tactics_display.sv */
module tb_tactics_display;
    import tactics_pkg::*;

    typedef struct packed {
        coord_t      scroll_x;
        coord_t      scroll_y;
        unit_t       knight;
        unit_t       wizard;
        anim_count_t anim;
        map_addr_t   selected;
        map_addr_t   action;
        unit_state_e state;
    } scenario_t;

    localparam int NUM_ROWS     = 7;
    localparam int FRAME_CYCLES = 420000;   // 800 x 525

    logic        pclk = 1'b0;
    logic        reset;
    coord_t      scroll_x_i;
    coord_t      scroll_y_i;
    logic        map_we_i;
    map_addr_t   map_waddr_i;
    tile_kind_t  map_wdata_i;
    unit_t       knight_i;
    unit_t       wizard_i;
    anim_count_t anim_count_i;
    map_addr_t   selected_i;
    map_addr_t   action_i;
    unit_state_e player_state_i;
    rgb_t        rgb_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        de_o;

    scenario_t  rows [NUM_ROWS];
    tile_kind_t map_copy [MAP_DEPTH];
    int         errors;
    int         checks;
    int         cur_x;
    int         cur_y;

    tactics_display uut (.*);

    always #2 pclk = ~pclk;

    initial begin
        #(NUM_ROWS * 2 * FRAME_CYCLES * 4);
        $display("timeout: the frames did not finish within the watchdog limit");
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic map_addr_t tile_at(int col, int row);
        return map_addr_t'(col + 40 * row);
    endfunction

    function automatic unit_t make_unit(map_addr_t pos, hp_t hp, unit_state_e st);
        unit_t u;
        u.pos   = pos;
        u.hp    = hp;
        u.state = st;
        return u;
    endfunction

    task automatic check_rgb(string name, rgb_t got, rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %03h expected %03h (x %0d y %0d)",
                     $time, name, got, exp, cur_x, cur_y);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference pixel model
    ////////////////////////////////////////////////////////////////////////////

    function automatic rgb_t expected_rgb(scenario_t r, int x, int y);
        int          sx;
        int          sy;
        int          tx;
        int          ty;
        map_addr_t   addr;
        tile_kind_t  kind;
        unit_t       u;
        hp_t         hp_max;
        rgb_t        body;
        rgb_t        pix;
        logic        has_unit;
        logic        is_bar;
        logic        band;
        logic        in_range;
        logic        frame;
        logic        tint;

        sx   = x + int'(r.scroll_x);
        sy   = y + int'(r.scroll_y);
        tx   = sx % 32;
        ty   = sy % 32;
        addr = map_addr_t'(sx / 32 + 40 * (sy / 32));
        kind = map_copy[addr];
        pix  = TILE_PALETTE[kind];
        is_bar   = 1'b0;
        has_unit = 1'b1;
        u        = r.knight;
        hp_max   = KNIGHT_HP_MAX;
        body     = COLOR_KNIGHT;
        if (r.knight.hp != 0 && r.knight.pos == addr) begin
            u = r.knight;
        end else if (r.wizard.hp != 0 && r.wizard.pos == addr) begin
            u      = r.wizard;
            hp_max = WIZARD_HP_MAX;
            body   = COLOR_WIZARD;
        end else begin
            has_unit = 1'b0;
        end

        if (has_unit && ty >= 2 && ty <= 3) begin
            is_bar = 1'b1;
            pix = (tx < 32 * int'(u.hp) / int'(hp_max)) ? COLOR_BAR_FULL : COLOR_BAR_EMPTY;
        end else if (has_unit && tx >= 8 && tx <= 23 && ty >= 6 && ty <= 29) begin
            pix = body;
            if (u.state == STATE_HIT && r.anim > 8)
                pix = body + HIT_FLASH;
        end

        band = tx < 2 || tx >= 30 || ty < 2 || ty >= 30;
        if (r.action == r.knight.pos)   // knight: four neighbours
            in_range = addr == r.action - 11'd1 || addr == r.action + 11'd1 ||
                       addr == r.action - 11'd40 || addr == r.action + 11'd40;
        else
            in_range = (int'(addr) / 40 == int'(r.action) / 40) ||
                       (int'(addr) % 40 == int'(r.action) % 40);

        frame = 1'b0;
        tint  = 1'b0;
        if (r.state == STATE_MOVE || r.state == STATE_ATTACK) begin
            if (addr == r.selected) begin
                frame = band;
                tint  = !band;
            end else begin
                frame = band && in_range && kind < 3;
            end
        end

        if (frame)
            return (r.state == STATE_ATTACK) ? COLOR_ATTACK : COLOR_MOVE;
        if (tint && !is_bar)
            return pix + ((r.state == STATE_ATTACK) ? TINT_ATTACK : TINT_MOVE);
        return pix;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and frame checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_map();
        logic [31:0] seed;
        map_addr_t   a;
        seed = 32'd9599;
        for (int i = 0; i < MAP_DEPTH; i++) begin
            seed = xorshift(seed);
            a    = map_addr_t'(i);
            map_copy[a] = tile_kind_t'(seed % 5);
            @(negedge pclk);
            map_we_i    = 1'b1;
            map_waddr_i = a;
            map_wdata_i = map_copy[a];
        end
        @(negedge pclk);
        map_we_i = 1'b0;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        prev = vsync_o;
        @(negedge pclk);
        while (!(prev && !vsync_o)) begin
            prev = vsync_o;
            @(negedge pclk);
        end
    endtask

    task automatic apply_row(scenario_t r);
        scroll_x_i     = r.scroll_x;
        scroll_y_i     = r.scroll_y;
        knight_i       = r.knight;
        wizard_i       = r.wizard;
        anim_count_i   = r.anim;
        selected_i     = r.selected;
        action_i       = r.action;
        player_state_i = r.state;
    endtask

    // runs from one vsync fall up to the next one
    task automatic check_frame(scenario_t r);
        int   de_cnt;
        int   hs_cnt;
        int   vs_low;
        logic prev_de;
        logic prev_hs;
        logic prev_vs;
        de_cnt  = 0;
        hs_cnt  = 0;
        vs_low  = 0;
        cur_x   = 0;
        cur_y   = 0;
        prev_de = 1'b0;
        prev_hs = 1'b1;
        do begin
            if (!vsync_o)
                vs_low++;
            if (prev_hs && !hsync_o)
                hs_cnt++;
            if (de_o) begin
                check_rgb("rgb_o", rgb_o, expected_rgb(r, cur_x, cur_y));
                de_cnt++;
                cur_x++;
            end else begin
                check_rgb("rgb_o in blanking", rgb_o, '0);
                if (prev_de) begin
                    cur_x = 0;
                    cur_y++;
                end
            end
            prev_de = de_o;
            prev_hs = hsync_o;
            prev_vs = vsync_o;
            @(negedge pclk);
        end while (!(prev_vs && !vsync_o));
        check_count("de_o pixels", de_cnt, 640 * 480);
        check_count("hsync_o pulses", hs_cnt, 525);
        check_count("vsync_o low cycles", vs_low, 2 * 800);
    endtask

    initial begin
        int start;

        reset          = 1'b1;
        scroll_x_i     = '0;
        scroll_y_i     = '0;
        map_we_i       = 1'b0;
        map_waddr_i    = '0;
        map_wdata_i    = '0;
        knight_i       = '0;
        wizard_i       = '0;
        anim_count_i   = '0;
        selected_i     = '0;
        action_i       = '0;
        player_state_i = STATE_IDLE;
        errors = 0;
        checks = 0;

        // map only; hp 0 units and idle selection show nothing
        rows[0] = '{11'd0, 11'd0, make_unit(tile_at(3, 2), 7'd0, STATE_MOVE),
                    make_unit(tile_at(10, 5), 7'd0, STATE_IDLE), 4'd0,
                    tile_at(0, 0), tile_at(1, 1), STATE_IDLE};
        rows[1] = '{11'd100, 11'd37, make_unit(tile_at(5, 4), 7'd0, STATE_IDLE),
                    make_unit(tile_at(7, 3), 7'd0, STATE_IDLE), 4'd0,
                    tile_at(6, 6), tile_at(5, 4), STATE_IDLE};
        rows[2] = '{11'd639, 11'd1055, make_unit(tile_at(30, 40), 7'd0, STATE_IDLE),
                    make_unit(tile_at(25, 35), 7'd0, STATE_HIT), 4'd9,
                    tile_at(30, 40), tile_at(30, 40), STATE_IDLE};
        // knight flashes, move range around the knight
        rows[3] = '{11'd0, 11'd0, make_unit(tile_at(3, 2), 7'd64, STATE_HIT),
                    make_unit(tile_at(10, 5), 7'd40, STATE_MOVE), 4'd9,
                    tile_at(6, 6), tile_at(3, 2), STATE_MOVE};
        // wizard selected, attack row and column, count 8 gives no flash
        rows[4] = '{11'd16, 11'd8, make_unit(tile_at(3, 2), 7'd127, STATE_IDLE),
                    make_unit(tile_at(10, 5), 7'd80, STATE_HIT), 4'd8,
                    tile_at(10, 5), tile_at(10, 5), STATE_ATTACK};
        rows[5] = '{11'd0, 11'd0, make_unit(tile_at(3, 2), 7'd1, STATE_HIT),
                    make_unit(tile_at(4, 2), 7'd79, STATE_HIT), 4'd15,
                    tile_at(3, 2), tile_at(3, 2), STATE_HIT};
        // both units on one tile, knight drawn on top
        rows[6] = '{11'd0, 11'd0, make_unit(tile_at(8, 7), 7'd100, STATE_IDLE),
                    make_unit(tile_at(8, 7), 7'd50, STATE_HIT), 4'd12,
                    tile_at(0, 0), tile_at(8, 7), STATE_IDLE};

        repeat (10) @(negedge pclk);
        reset = 1'b0;
        write_map();
        wait_vsync_fall();

        for (int i = 0; i < NUM_ROWS; i++) begin
            start = errors;
            apply_row(rows[i]);
            check_frame(rows[i]);
            $display("row %0d finished: %0s (%0d errors)", i,
                     (errors == start) ? "ok" : "FAILED", errors - start);
        end

        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* verilog.f */
src/tactics_pkg.sv
src/scan_timing.sv
src/tile_map_ram.sv
src/unit_layer.sv
src/range_overlay.sv
src/pixel_compositor.sv
src/tactics_display.sv
tb/tb_tactics_display.sv
